//--- files.f
rtl/skencode_pkg.sv
rtl/coeff_mem.sv
rtl/eta_pack_unit.sv
rtl/pack_buffer.sv
rtl/skencode_ctrl.sv
rtl/skencode_top.sv
testbench/skencode_tb.sv

//--- testbench/skencode_tb.sv
`default_nettype none

module skencode_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int KEY_WORDS = skencode_pkg::KEY_WORDS;
    localparam int SRC_WORDS = skencode_pkg::SRC_WORDS;
    localparam int MEM_DEPTH = skencode_pkg::MEM_DEPTH;
    localparam int CYCLE_LIMIT = 20000;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        load_valid;
    logic [9:0]  load_addr;
    logic [95:0] load_data;
    logic        start;
    logic [9:0]  src_base;
    logic [9:0]  dest_base;
    logic        zeroize;
    logic        key_ready;
    logic        key_valid;
    logic [9:0]  key_addr;
    logic [31:0] key_data;
    logic        busy;
    logic        done;
    logic        error;

    // Copy of everything loaded into the coefficient memory.
    logic [95:0] mirror [0:MEM_DEPTH-1];

    logic [31:0] lfsr = 32'h24e0;
    logic        random_ready = 1'b0;
    int          cycles = 0;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    // Run state, shared by the stimulus and the monitor.
    int          run_src = 0;
    int          run_dst = 0;
    int          xfer_count = 0;
    int          done_count = 0;
    int          error_count = 0;
    logic        closed = 1'b0;
    logic        prev_stall = 1'b0;
    logic        prev_zero = 1'b0;
    logic        prev_last = 1'b0;
    logic [9:0]  prev_addr = '0;
    logic [31:0] prev_data = '0;

    skencode_top UUT (
        .clk        (clk),
        .reset_n    (reset_n),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .start      (start),
        .src_base   (src_base),
        .dest_base  (dest_base),
        .zeroize    (zeroize),
        .key_valid  (key_valid),
        .key_ready  (key_ready),
        .key_addr   (key_addr),
        .key_data   (key_data),
        .busy       (busy),
        .done       (done),
        .error      (error)
    );

    always #4 clk = ~clk;

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken.
    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // Expected key word j of a run reading from src, built bit by bit.
    // Each coefficient c becomes 2 - c mod Q in a 3-bit field.
    function automatic logic [31:0] expected_word(input int src, input int j);
        logic [31:0] w;
        int          s;
        int          grp;
        int          k;
        int          addr;
        int          c;
        int          m;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            s    = 32 * j + b;
            grp  = s / 24;
            k    = (s % 24) / 3;
            addr = (src + 2 * grp + k / 4) % MEM_DEPTH;
            c    = mirror[addr][(k % 4) * 24 +: 24];
            m    = (c <= 2) ? 2 - c : int'(skencode_pkg::MLDSA_Q) + 2 - c;
            w[b] = m[(s % 24) % 3];
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic load_word(input int addr, input logic [95:0] data);
        load_valid = 1'b1;
        load_addr  = addr[9:0];
        load_data  = data;
        @(posedge clk);
        #1;
        load_valid = 1'b0;
    endtask

    task automatic start_run(input int src, input int dst, input logic rand_rdy);
        run_src      = src;
        run_dst      = dst;
        xfer_count   = 0;
        done_count   = 0;
        error_count  = 0;
        closed       = 1'b0;
        random_ready = rand_rdy;
        src_base     = src[9:0];
        dest_base    = dst[9:0];
        start        = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_value("busy", busy, 1);
    endtask

    // Waits for done or error, then watches a while longer for stray words.
    task automatic wait_run_end();
        while (done_count == 0 && error_count == 0) begin
            @(posedge clk);
            #1;
        end
        repeat (20) @(posedge clk);
        #1;
    endtask

    task automatic check_complete_run();
        wait_run_end();
        check_value("done pulses", done_count, 1);
        check_value("error pulses", error_count, 0);
        check_value("key words", xfer_count, KEY_WORDS);
        check_value("busy", busy, 0);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("Test %s: PASS", name);
            tests_passed++;
        end else begin
            $display("Test %s: FAIL", name);
            tests_failed++;
        end
    endtask

    // ====================
    // Drivers and monitor
    // ====================
    always @(posedge clk) begin
        logic [31:0] bit_v;
        logic        use_random;
        use_random = random_ready;
        #1;
        if (use_random) begin
            random_bits(1, bit_v);
            key_ready = bit_v[0];
        end else begin
            key_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the runs did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (reset_n) begin
            // A stalled word must stay put unless the run was cleared.
            if (prev_stall && !prev_zero && !error) begin
                if (!key_valid) begin
                    report_failure("key_valid dropped while the stream was stalled");
                end
                check_value("key_addr", key_addr, prev_addr);
                check_value("key_data", key_data, prev_data);
            end
            if (done) begin
                done_count++;
                check_value("key words at done", xfer_count, KEY_WORDS);
                check_value("last word one cycle before done", prev_last, 1);
            end
            if (error) begin
                error_count++;
                closed = 1'b1;
            end
            if (key_valid && key_ready) begin
                if (closed) begin
                    report_failure("A key word was transferred after the run ended");
                end else if (xfer_count >= KEY_WORDS) begin
                    report_failure("More key words were transferred than one run holds");
                end else begin
                    check_value("key_addr", key_addr, (run_dst + xfer_count) % MEM_DEPTH);
                    check_value("key_data", key_data, expected_word(run_src, xfer_count));
                end
                xfer_count++;
            end
            if (zeroize) begin
                closed = 1'b1;
            end
            prev_last  = key_valid && key_ready && xfer_count == KEY_WORDS;
            prev_stall = key_valid && !key_ready;
            prev_zero  = zeroize;
            prev_addr  = key_addr;
            prev_data  = key_data;
        end
    end

    // ====================
    // Stimulus
    // ====================
    initial begin
        logic [31:0] v;
        int          e0;
        reset_n    = 1'b0;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        start      = 1'b0;
        src_base   = '0;
        dest_base  = '0;
        zeroize    = 1'b0;
        key_ready  = 1'b0;

        // Every coefficient is drawn from the legal set {0, 1, 2, Q-1, Q-2}.
        for (int a = 0; a < MEM_DEPTH; a++) begin
            for (int i = 0; i < 4; i++) begin
                random_bits(3, v);
                case (v % 5)
                    0: mirror[a][i*24 +: 24] = 24'd0;
                    1: mirror[a][i*24 +: 24] = 24'd1;
                    2: mirror[a][i*24 +: 24] = 24'd2;
                    3: mirror[a][i*24 +: 24] = 24'(skencode_pkg::MLDSA_Q - 1);
                    default: mirror[a][i*24 +: 24] = 24'(skencode_pkg::MLDSA_Q - 2);
                endcase
            end
        end

        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;

        e0 = errors;
        check_value("key_valid", key_valid, 0);
        check_value("busy", busy, 0);
        check_value("done", done, 0);
        check_value("error", error, 0);
        finish_test("reset state", e0);

        for (int a = 0; a < MEM_DEPTH; a++) begin
            load_word(a, mirror[a]);
        end

        e0 = errors;
        start_run(0, 0, 1'b0);
        check_complete_run();
        finish_test("full encode", e0);

        e0 = errors;
        start_run(0, 0, 1'b1);
        check_complete_run();
        finish_test("random back-pressure", e0);

        e0 = errors;
        start_run(MEM_DEPTH - SRC_WORDS, 100, 1'b1);
        check_complete_run();
        finish_test("shifted base addresses", e0);

        // One bad coefficient in the middle of the source region.
        e0 = errors;
        mirror[300][2*24 +: 24] = 24'd3;
        load_word(300, mirror[300]);
        start_run(0, 0, 1'b0);
        wait_run_end();
        check_value("error pulses", error_count, 1);
        check_value("done pulses", done_count, 0);
        check_value("busy", busy, 0);
        finish_test("illegal coefficient", e0);

        e0 = errors;
        mirror[300][2*24 +: 24] = 24'd0;
        load_word(300, mirror[300]);
        start_run(0, 0, 1'b1);
        while (xfer_count < 200) begin
            @(posedge clk);
            #1;
        end
        zeroize = 1'b1;
        @(posedge clk);
        #1;
        zeroize = 1'b0;
        repeat (50) @(posedge clk);
        #1;
        check_value("done pulses", done_count, 0);
        check_value("error pulses", error_count, 0);
        check_value("busy", busy, 0);
        check_value("key_valid", key_valid, 0);
        finish_test("zeroize midway", e0);

        e0 = errors;
        start_run(0, 0, 1'b1);
        check_complete_run();
        finish_test("clean run after abort", e0);

        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/skencode_top.sv
`default_nettype none

module skencode_top (
    input  wire                                   clk,
    input  wire                                   reset_n,

    // Host load port.
    input  wire                                   load_valid,
    input  wire  [skencode_pkg::SRC_ADDR_W-1:0]   load_addr,
    input  wire  [skencode_pkg::MEM_W-1:0]        load_data,

    // Run control.
    input  wire                                   start,
    input  wire  [skencode_pkg::SRC_ADDR_W-1:0]   src_base,
    input  wire  [skencode_pkg::KEY_ADDR_W-1:0]   dest_base,
    input  wire                                   zeroize,

    // Key word stream.
    output logic                                  key_valid,
    input  wire                                   key_ready,
    output logic [skencode_pkg::KEY_ADDR_W-1:0]   key_addr,
    output logic [skencode_pkg::KEY_W-1:0]        key_data,

    // Status.
    output logic                                  busy,
    output logic                                  done,
    output logic                                  error
);

    // ====================
    // Internal wires
    // ====================
    logic                                rd_en;
    logic [skencode_pkg::SRC_ADDR_W-1:0] rd_addr_a;
    logic [skencode_pkg::SRC_ADDR_W-1:0] rd_addr_b;
    logic [skencode_pkg::MEM_W-1:0]      rd_data_a;
    logic [skencode_pkg::MEM_W-1:0]      rd_data_b;
    logic [skencode_pkg::GROUP_W-1:0]    group;
    logic                                group_bad;
    logic                                group_valid;
    logic                                room;
    logic                                flush;

    coeff_mem u_coeff_mem (
        .clk        (clk),
        .reset_n    (reset_n),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rd_en      (rd_en),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b)
    );

    eta_pack_unit u_eta_pack_unit (
        .word_a    (rd_data_a),
        .word_b    (rd_data_b),
        .group     (group),
        .group_bad (group_bad)
    );

    pack_buffer u_pack_buffer (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .flush       (flush),
        .group_valid (group_valid),
        .group       (group),
        .room        (room),
        .key_valid   (key_valid),
        .key_data    (key_data),
        .key_ready   (key_ready)
    );

    skencode_ctrl u_skencode_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .start       (start),
        .src_base    (src_base),
        .dest_base   (dest_base),
        .room        (room),
        .group_bad   (group_bad),
        .key_valid   (key_valid),
        .key_ready   (key_ready),
        .rd_en       (rd_en),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .group_valid (group_valid),
        .flush       (flush),
        .key_addr    (key_addr),
        .busy        (busy),
        .done        (done),
        .error       (error)
    );

endmodule

`default_nettype wire

//--- rtl/skencode_ctrl.sv
`default_nettype none

module skencode_ctrl (
    input  wire                                   clk,
    input  wire                                   reset_n,
    input  wire                                   zeroize,

    input  wire                                   start,
    input  wire  [skencode_pkg::SRC_ADDR_W-1:0]   src_base,
    input  wire  [skencode_pkg::KEY_ADDR_W-1:0]   dest_base,

    input  wire                                   room,
    input  wire                                   group_bad,
    input  wire                                   key_valid,
    input  wire                                   key_ready,

    output logic                                  rd_en,
    output logic [skencode_pkg::SRC_ADDR_W-1:0]   rd_addr_a,
    output logic [skencode_pkg::SRC_ADDR_W-1:0]   rd_addr_b,
    output logic                                  group_valid,
    output logic                                  flush,
    output logic [skencode_pkg::KEY_ADDR_W-1:0]   key_addr,
    output logic                                  busy,
    output logic                                  done,
    output logic                                  error
);

    localparam int PW = skencode_pkg::PAIR_W;
    localparam int KW = skencode_pkg::KEY_ADDR_W;

    logic [1:0]                          state;
    logic [PW-1:0]                       pair_cnt;
    logic [KW-1:0]                       key_cnt;
    logic [skencode_pkg::SRC_ADDR_W-1:0] src_q;
    logic [KW-1:0]                       dest_q;

    logic abort;
    logic xfer;
    logic last_pair;
    logic last_word;

    assign abort     = group_valid && group_bad;
    assign xfer      = key_valid && key_ready;
    assign last_pair = pair_cnt == PW'(skencode_pkg::RD_PAIRS - 1);
    assign last_word = key_cnt == KW'(skencode_pkg::KEY_WORDS - 1);

    // No read issues in the cycle a bad group shows up, so nothing is left
    // in flight once the run aborts.
    assign rd_en     = (state == skencode_pkg::ST_READ) && room && !abort;
    assign rd_addr_a = src_q + {pair_cnt, 1'b0};
    assign rd_addr_b = rd_addr_a + skencode_pkg::SRC_ADDR_W'(1);

    assign flush    = abort;
    assign busy     = state != skencode_pkg::ST_IDLE;
    assign key_addr = dest_q + key_cnt;

    // ====================
    // Run FSM
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= skencode_pkg::ST_IDLE;
            pair_cnt    <= '0;
            key_cnt     <= '0;
            src_q       <= '0;
            dest_q      <= '0;
            group_valid <= 1'b0;
            done        <= 1'b0;
            error       <= 1'b0;
        end else if (zeroize) begin
            state       <= skencode_pkg::ST_IDLE;
            pair_cnt    <= '0;
            key_cnt     <= '0;
            src_q       <= '0;
            dest_q      <= '0;
            group_valid <= 1'b0;
            done        <= 1'b0;
            error       <= 1'b0;
        end else begin
            group_valid <= rd_en;
            error       <= abort;
            done        <= 1'b0;
            if (abort) begin
                state <= skencode_pkg::ST_IDLE;
            end else begin
                case (state)
                    skencode_pkg::ST_IDLE: begin
                        if (start) begin
                            src_q    <= src_base;
                            dest_q   <= dest_base;
                            pair_cnt <= '0;
                            key_cnt  <= '0;
                            state    <= skencode_pkg::ST_READ;
                        end
                    end
                    skencode_pkg::ST_READ: begin
                        if (rd_en) begin
                            pair_cnt <= pair_cnt + PW'(1);
                            if (last_pair) begin
                                state <= skencode_pkg::ST_DRAIN;
                            end
                        end
                        if (xfer) begin
                            key_cnt <= key_cnt + KW'(1);
                        end
                    end
                    skencode_pkg::ST_DRAIN: begin
                        // The last word needs the last group, so it always lands here.
                        if (xfer) begin
                            key_cnt <= key_cnt + KW'(1);
                            if (last_word) begin
                                state <= skencode_pkg::ST_IDLE;
                                done  <= 1'b1;
                            end
                        end
                    end
                    default: begin
                        state <= skencode_pkg::ST_IDLE;
                    end
                endcase
            end
        end
    end

    // An idle machine issues no read and has no group still in flight.
    idle_no_read: assert property (
        @(posedge clk) disable iff (!reset_n)
        (state == skencode_pkg::ST_IDLE) |-> (!rd_en && !group_valid)
    );

endmodule

`default_nettype wire

//--- rtl/pack_buffer.sv
`default_nettype none

module pack_buffer (
    input  wire                                clk,
    input  wire                                reset_n,
    input  wire                                zeroize,
    input  wire                                flush,

    input  wire                                group_valid,
    input  wire  [skencode_pkg::GROUP_W-1:0]   group,
    output logic                               room,

    output logic                               key_valid,
    output logic [skencode_pkg::KEY_W-1:0]     key_data,
    input  wire                                key_ready
);

    localparam int ACC_W = skencode_pkg::ACC_W;
    localparam int CNT_W = skencode_pkg::ACC_CNT_W;

    // Bits above the count are always zero, so a new group can be OR'ed in.
    logic [ACC_W-1:0] acc;
    logic [CNT_W-1:0] count;

    logic             xfer;
    logic [ACC_W-1:0] acc_shift;
    logic [CNT_W-1:0] count_shift;
    logic [ACC_W-1:0] group_ins;

    // ====================
    // Output stream
    // ====================
    assign key_valid = count >= CNT_W'(skencode_pkg::KEY_W);
    assign key_data  = acc[skencode_pkg::KEY_W-1:0];
    assign xfer      = key_valid && key_ready;

    // One read may still be in flight when room is sampled, so room leaves
    // space for two whole groups.
    assign room = count <= CNT_W'(ACC_W - 2 * skencode_pkg::GROUP_W);

    // ====================
    // Accumulator
    // ====================
    // A transferred word leaves first, then the new group lands right above
    // the bits that remain.
    always_comb begin
        if (xfer) begin
            acc_shift   = acc >> skencode_pkg::KEY_W;
            count_shift = count - CNT_W'(skencode_pkg::KEY_W);
        end else begin
            acc_shift   = acc;
            count_shift = count;
        end
        group_ins = {{(ACC_W - skencode_pkg::GROUP_W){1'b0}}, group} << count_shift;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc   <= '0;
            count <= '0;
        end else if (zeroize || flush) begin
            acc   <= '0;
            count <= '0;
        end else if (group_valid) begin
            acc   <= acc_shift | group_ins;
            count <= count_shift + CNT_W'(skencode_pkg::GROUP_W);
        end else begin
            acc   <= acc_shift;
            count <= count_shift;
        end
    end

    // ====================
    // Checks
    // ====================
    // The controller's early room check is what keeps the count in range.
    count_in_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        count <= CNT_W'(ACC_W)
    );

    // A stalled word stays offered and unchanged.
    stall_holds_data: assert property (
        @(posedge clk) disable iff (!reset_n)
        (key_valid && !key_ready && !zeroize && !flush) |=> (key_valid && $stable(key_data))
    );

endmodule

`default_nettype wire

//--- rtl/eta_pack_unit.sv
`default_nettype none

module eta_pack_unit (
    input  wire  [skencode_pkg::MEM_W-1:0]   word_a,
    input  wire  [skencode_pkg::MEM_W-1:0]   word_b,
    output logic [skencode_pkg::GROUP_W-1:0] group,
    output logic                             group_bad
);

    localparam int CW = skencode_pkg::COEFF_W;
    localparam int EB = skencode_pkg::ETA_BITS;
    localparam int CPW = skencode_pkg::COEFFS_PER_WORD;

    // Maps one coefficient to 2 - c mod Q. Bit 3 of the result flags a value
    // outside [-2, 2].
    function automatic logic [3:0] map_coeff(input logic [CW-1:0] c);
        logic [3:0] res;
        case (c)
            CW'(0):                         res = 4'b0_010;
            CW'(1):                         res = 4'b0_001;
            CW'(2):                         res = 4'b0_000;
            CW'(skencode_pkg::MLDSA_Q - 1): res = 4'b0_011;
            CW'(skencode_pkg::MLDSA_Q - 2): res = 4'b0_100;
            default:                        res = 4'b1_000;
        endcase
        return res;
    endfunction

    // The even word fills the low half of the group and the odd word the
    // high half, coefficient 0 lowest in each.
    always_comb begin
        logic [3:0] res_a;
        logic [3:0] res_b;
        group     = '0;
        group_bad = 1'b0;
        for (int i = 0; i < CPW; i++) begin
            res_a = map_coeff(word_a[i*CW +: CW]);
            res_b = map_coeff(word_b[i*CW +: CW]);
            group[i*EB +: EB]         = res_a[EB-1:0];
            group[(CPW+i)*EB +: EB]   = res_b[EB-1:0];
            group_bad                 = group_bad | res_a[3] | res_b[3];
        end
    end

endmodule

`default_nettype wire

//--- rtl/coeff_mem.sv
`default_nettype none

module coeff_mem (
    input  wire                                   clk,
    input  wire                                   reset_n,

    input  wire                                   load_valid,
    input  wire  [skencode_pkg::SRC_ADDR_W-1:0]   load_addr,
    input  wire  [skencode_pkg::MEM_W-1:0]        load_data,

    input  wire                                   rd_en,
    input  wire  [skencode_pkg::SRC_ADDR_W-1:0]   rd_addr_a,
    input  wire  [skencode_pkg::SRC_ADDR_W-1:0]   rd_addr_b,
    output logic [skencode_pkg::MEM_W-1:0]        rd_data_a,
    output logic [skencode_pkg::MEM_W-1:0]        rd_data_b
);

    // Coefficient storage, four coefficients per word.
    logic [skencode_pkg::MEM_W-1:0] mem [0:skencode_pkg::MEM_DEPTH-1];

    // ====================
    // Host load port
    // ====================
    // One write per cycle, always accepted.
    always_ff @(posedge clk) begin
        if (load_valid) begin
            mem[load_addr] <= load_data;
        end
    end

    // ====================
    // Read ports
    // ====================
    // Both ports return data one cycle after rd_en. The output registers
    // keep their last value while no read is issued.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_data_a <= '0;
            rd_data_b <= '0;
        end else if (rd_en) begin
            rd_data_a <= mem[rd_addr_a];
            rd_data_b <= mem[rd_addr_b];
        end
    end

endmodule

`default_nettype wire

//--- rtl/skencode_pkg.sv
`default_nettype none

package skencode_pkg;

    // ====================
    // ML-DSA parameter set
    // ====================
    localparam logic [22:0] MLDSA_Q = 23'd8380417;
    localparam int MLDSA_N = 256;
    localparam int MLDSA_L = 7;
    localparam int MLDSA_K = 8;

    // Source memory layout. Four coefficients share one memory word.
    localparam int COEFF_W         = 24;
    localparam int COEFFS_PER_WORD = 4;
    localparam int MEM_W           = COEFF_W * COEFFS_PER_WORD;
    localparam int SRC_ADDR_W      = 10;
    localparam int MEM_DEPTH       = 1 << SRC_ADDR_W;

    // Packed key format. Eight 3-bit fields form one group per cycle.
    localparam int ETA_BITS   = 3;
    localparam int GROUP_W    = 2 * COEFFS_PER_WORD * ETA_BITS;
    localparam int KEY_W      = 32;
    localparam int KEY_ADDR_W = 10;
    localparam int ACC_W      = 64;
    localparam int ACC_CNT_W  = $clog2(ACC_W + 1);

    // Run lengths.
    localparam int SRC_WORDS = (MLDSA_L + MLDSA_K) * MLDSA_N / COEFFS_PER_WORD;
    localparam int KEY_WORDS = (MLDSA_L + MLDSA_K) * MLDSA_N * ETA_BITS / KEY_W;
    localparam int RD_PAIRS  = SRC_WORDS / 2;
    localparam int PAIR_W    = SRC_ADDR_W - 1;

    // ====================
    // Controller states
    // ====================
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_READ  = 2'd1;
    localparam logic [1:0] ST_DRAIN = 2'd2;

endpackage

`default_nettype wire
